//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_qnet_cmd_proc -Mdir obj_dir
	./obj_dir/Vtb_qnet_cmd_proc 2>&1 | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- source/qnet_cmd_exec.sv
`timescale 1ns/1ns

module qnet_cmd_exec (
   input  logic                           t_clk_i,
   input  logic                           t_rst_ni,
   input  logic                           t_ready_i,
   input  logic                           cmd_start_i,
   input  logic                           cmd_net_i,
   input  logic                           abort_i,
   input  logic [qnet_pkg::HDR_W-1:0]     cmd_header_i,
   input  logic [qnet_pkg::DT_W-1:0]      cmd_dt0_i,
   input  logic [qnet_pkg::DT_W-1:0]      cmd_dt1_i,
   input  logic [qnet_pkg::NODE_ID_W-1:0] node_id_i,
   input  logic [qnet_pkg::DT_W-1:0]      t_link_i,
   input  logic                           tx_done_i,
   output logic                           cmd_done_o,
   output logic                           cmd_error_o,
   output qnet_pkg::param_sel_e           param_we_o,
   output logic [qnet_pkg::DT_W-1:0]      param_dt_o,
   output logic                           time_reset_o,
   output logic                           time_init_o,
   output logic                           time_updt_o,
   output logic                           tx_load_o,
   output logic [qnet_pkg::HDR_W-1:0]     tx_header_o,
   output logic [qnet_pkg::DT_W-1:0]      tx_dt0_o,
   output logic [qnet_pkg::DT_W-1:0]      tx_dt1_o
);
   import qnet_pkg::*;

   exec_st_e         st_q;
   exec_st_e         st_d;
   logic [OPC_W-1:0] opc_raw;
   logic             opc_legal;
   qnet_opc_e        opc_q;
   logic             net_q;         // Command came from the network
   logic             fire;          // Tick cycle of a legal command

   ////////////////////////////////////////
   // Decode

   assign opc_raw = cmd_header_i[HDR_OPC_LSB +: OPC_W];

   always_comb begin
      case (opc_raw)
         OPC_GET_NET, OPC_SET_NET, OPC_SYNC1, OPC_UPDT_OFF, OPC_SET_DT: opc_legal = 1'b1;
         default: opc_legal = 1'b0;
      endcase
   end

   always_ff @(posedge t_clk_i) begin
      if (st_q == X_IDLE && cmd_start_i) begin
         opc_q <= qnet_opc_e'(opc_raw);
         net_q <= cmd_net_i;
      end
   end

   ////////////////////////////////////////
   // FSM

   always_comb begin
      st_d = st_q;
      case (st_q)
         X_IDLE: begin
            if (cmd_start_i) begin
               if (opc_legal) st_d = X_WAIT_TICK;
               else           st_d = X_ERROR;
            end
         end
         X_WAIT_TICK: if (t_ready_i) st_d = X_WAIT_TX;
         X_ERROR:     st_d = X_IDLE;         // One cycle only
         X_WAIT_TX:   if (tx_done_i) st_d = X_IDLE;
         default:     st_d = X_IDLE;
      endcase
      if (abort_i) st_d = X_IDLE;
   end

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         st_q       <= X_IDLE;
         cmd_done_o <= 1'b0;
      end else begin
         st_q       <= st_d;
         cmd_done_o <= ~abort_i & ((st_q == X_WAIT_TX && tx_done_i) || st_q == X_ERROR);
      end
   end

   assign cmd_error_o = (st_q == X_ERROR);
   assign fire        = (st_q == X_WAIT_TICK) && t_ready_i && !abort_i;

   ////////////////////////////////////////
   // Tick-cycle actions

   always_comb begin
      param_we_o   = P_NONE;
      param_dt_o   = DT_W'(node_id_i);   // Idle value echoes the node ID
      time_reset_o = 1'b0;
      time_init_o  = 1'b0;
      time_updt_o  = 1'b0;
      tx_load_o    = fire;
      tx_header_o  = cmd_header_i;
      tx_dt0_o     = cmd_dt0_i;
      tx_dt1_o     = cmd_dt1_i;
      if (fire) begin
         if (!net_q) begin
            case (opc_q)
               OPC_GET_NET: begin
                  tx_dt0_o     = '0;
                  tx_dt1_o     = '0;
                  param_we_o   = P_ID;
                  param_dt_o   = DT_W'(1);    // Origin node takes ID 1
                  time_reset_o = 1'b1;
               end
               OPC_SET_NET, OPC_SYNC1: begin
                  tx_dt0_o     = t_link_i;
                  tx_dt1_o     = '0;
                  time_reset_o = 1'b1;
               end
               default: ;                     // Sent as received
            endcase
         end else begin
            case (opc_q)
               OPC_GET_NET: begin
                  tx_header_o = cmd_header_i + HDR_W'(1);   // Next node gets ID + 1
                  tx_dt0_o    = '0;
                  tx_dt1_o    = '0;
                  param_we_o  = P_ID;
                  param_dt_o  = DT_W'(cmd_header_i[HDR_NID_LSB +: NODE_ID_W]);
               end
               OPC_SET_NET: begin
                  param_we_o = P_NN;
                  param_dt_o = DT_W'(cmd_header_i[HDR_NID_LSB +: NODE_ID_W]);
               end
               OPC_SYNC1: begin
                  tx_dt0_o    = cmd_dt0_i + t_link_i;   // Accumulate link delay
                  tx_dt1_o    = '0;
                  param_we_o  = P_OFF;
                  param_dt_o  = cmd_dt0_i + cmd_dt1_i;
                  time_init_o = 1'b1;
               end
               OPC_UPDT_OFF: begin
                  param_we_o  = P_OFF;
                  param_dt_o  = cmd_dt0_i;
                  time_updt_o = 1'b1;
               end
               OPC_SET_DT: begin
                  param_we_o = P_DT;
                  param_dt_o = cmd_dt0_i;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

//--- source/qnet_cmd_intake.sv
`timescale 1ns/1ns

module qnet_cmd_intake (
   input  logic t_clk_i,
   input  logic t_rst_ni,
   input  logic link_ready_i,
   input  logic t_ready_i,         // Time-base tick
   input  logic loc_cmd_req_i,
   input  logic net_cmd_req_i,
   input  logic cmd_done_i,
   output logic loc_cmd_ack_o,
   output logic net_cmd_ack_o,
   output logic c_ready_o,
   output logic cmd_start_o,
   output logic cmd_net_o,         // Source of the started command
   output logic abort_o
);
   import qnet_pkg::*;

   intake_st_e          st_q;
   intake_st_e          st_d;
   logic [TO_CNT_W-1:0] to_cnt_q;
   logic                time_out;
   logic                fault;
   logic                grant_loc;
   logic                grant_net;
   logic                req_gone;

   assign time_out = (to_cnt_q == TO_CNT_W'(TIMEOUT_TICKS));
   assign fault    = ~link_ready_i | time_out;

   // Local request wins over the network
   always_comb begin
      st_d      = st_q;
      grant_loc = 1'b0;
      grant_net = 1'b0;
      req_gone  = 1'b0;
      case (st_q)
         I_NOT_READY: if (link_ready_i) st_d = I_IDLE;
         I_IDLE: begin
            if (loc_cmd_req_i) begin
               grant_loc = 1'b1;
               st_d      = I_BUSY;
            end else if (net_cmd_req_i) begin
               grant_net = 1'b1;
               st_d      = I_BUSY;
            end
         end
         I_BUSY:      if (cmd_done_i) st_d = I_WAIT_NREQ;
         I_WAIT_NREQ: begin
            req_gone = loc_cmd_ack_o ? ~loc_cmd_req_i : ~net_cmd_req_i;
            if (req_gone) st_d = I_IDLE;
         end
         default:     st_d = I_NOT_READY;
      endcase
      if (fault) st_d = I_NOT_READY;   // Link loss or timeout overrides all
   end

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         st_q          <= I_NOT_READY;
         loc_cmd_ack_o <= 1'b0;
         net_cmd_ack_o <= 1'b0;
         cmd_start_o   <= 1'b0;
         cmd_net_o     <= 1'b0;
         abort_o       <= 1'b0;
         to_cnt_q      <= '0;
      end else begin
         st_q        <= st_d;
         cmd_start_o <= ~fault & (grant_loc | grant_net);
         cmd_net_o   <= ~fault & grant_net;
         abort_o     <= fault & (st_q != I_NOT_READY);
         if (fault || req_gone) begin
            loc_cmd_ack_o <= 1'b0;
            net_cmd_ack_o <= 1'b0;
         end else begin
            if (grant_loc) loc_cmd_ack_o <= 1'b1;
            if (grant_net) net_cmd_ack_o <= 1'b1;
         end
         // Ticks counted only while a command is in flight
         if (!fault && (st_q == I_BUSY || st_q == I_WAIT_NREQ)) begin
            if (t_ready_i) to_cnt_q <= to_cnt_q + 1'b1;
         end else begin
            to_cnt_q <= '0;
         end
      end
   end

   assign c_ready_o = (st_q == I_IDLE);

endmodule

//--- source/qnet_cmd_proc.sv
`timescale 1ns/1ns

module qnet_cmd_proc (
   input  logic                           t_clk_i,
   input  logic                           t_rst_ni,
   input  logic                           link_ready_i,
   input  logic                           t_ready_i,
   input  logic [qnet_pkg::NODE_ID_W-1:0] node_id_i,
   input  logic [qnet_pkg::DT_W-1:0]      t_link_i,
   input  logic                           loc_cmd_req_i,
   input  logic                           net_cmd_req_i,
   input  logic [qnet_pkg::HDR_W-1:0]     cmd_header_i,
   input  logic [qnet_pkg::DT_W-1:0]      cmd_dt0_i,
   input  logic [qnet_pkg::DT_W-1:0]      cmd_dt1_i,
   output logic                           loc_cmd_ack_o,
   output logic                           net_cmd_ack_o,
   output logic                           c_ready_o,
   output logic                           cmd_error_o,
   output qnet_pkg::param_sel_e           param_we_o,
   output logic [qnet_pkg::DT_W-1:0]      param_dt_o,
   output logic                           time_reset_o,
   output logic                           time_init_o,
   output logic                           time_updt_o,
   output logic                           tx_req_o,
   output logic [qnet_pkg::HDR_W-1:0]     tx_header_o,
   output logic [qnet_pkg::DT_W-1:0]      tx_dt0_o,
   output logic [qnet_pkg::DT_W-1:0]      tx_dt1_o,
   input  logic                           tx_ack_i
);
   import qnet_pkg::*;

   logic             cmd_start;
   logic             cmd_net;
   logic             cmd_done;
   logic             abort;          // Also flushes the holding register
   logic             tx_load;
   logic [HDR_W-1:0] tx_header;
   logic [DT_W-1:0]  tx_dt0;
   logic [DT_W-1:0]  tx_dt1;
   logic             tx_done;

   ////////////////////////////////////////
   // Request side

   qnet_cmd_intake u_intake (
      .t_clk_i       (t_clk_i),
      .t_rst_ni      (t_rst_ni),
      .link_ready_i  (link_ready_i),
      .t_ready_i     (t_ready_i),
      .loc_cmd_req_i (loc_cmd_req_i),
      .net_cmd_req_i (net_cmd_req_i),
      .cmd_done_i    (cmd_done),
      .loc_cmd_ack_o (loc_cmd_ack_o),
      .net_cmd_ack_o (net_cmd_ack_o),
      .c_ready_o     (c_ready_o),
      .cmd_start_o   (cmd_start),
      .cmd_net_o     (cmd_net),
      .abort_o       (abort)
   );

   ////////////////////////////////////////
   // Execution and transmit holding

   qnet_cmd_exec u_exec (
      .t_clk_i      (t_clk_i),
      .t_rst_ni     (t_rst_ni),
      .t_ready_i    (t_ready_i),
      .cmd_start_i  (cmd_start),
      .cmd_net_i    (cmd_net),
      .abort_i      (abort),
      .cmd_header_i (cmd_header_i),
      .cmd_dt0_i    (cmd_dt0_i),
      .cmd_dt1_i    (cmd_dt1_i),
      .node_id_i    (node_id_i),
      .t_link_i     (t_link_i),
      .tx_done_i    (tx_done),
      .cmd_done_o   (cmd_done),
      .cmd_error_o  (cmd_error_o),
      .param_we_o   (param_we_o),
      .param_dt_o   (param_dt_o),
      .time_reset_o (time_reset_o),
      .time_init_o  (time_init_o),
      .time_updt_o  (time_updt_o),
      .tx_load_o    (tx_load),
      .tx_header_o  (tx_header),
      .tx_dt0_o     (tx_dt0),
      .tx_dt1_o     (tx_dt1)
   );

   qnet_tx_hold u_tx (
      .t_clk_i     (t_clk_i),
      .t_rst_ni    (t_rst_ni),
      .tx_load_i   (tx_load),
      .flush_i     (abort),
      .tx_header_i (tx_header),
      .tx_dt0_i    (tx_dt0),
      .tx_dt1_i    (tx_dt1),
      .tx_ack_i    (tx_ack_i),
      .tx_req_o    (tx_req_o),
      .tx_header_o (tx_header_o),
      .tx_dt0_o    (tx_dt0_o),
      .tx_dt1_o    (tx_dt1_o),
      .tx_done_o   (tx_done)
   );

endmodule

//--- source/qnet_pkg.sv
package qnet_pkg;

   ////////////////////////////////////////
   // Header layout

   localparam int DT_W      = 32;
   localparam int NODE_ID_W = 10;
   localparam int OPC_W     = 5;
   localparam int TYPE_W    = 2;
   localparam int FLG_W     = 3;            // Flags only pass through
   localparam int HDR_DAT_W = 24;

   // Fields stacked from bit 0 upwards
   localparam int HDR_DAT_LSB  = 0;
   localparam int HDR_STEP_LSB = HDR_DAT_LSB + HDR_DAT_W;      // 24
   localparam int HDR_SRC_LSB  = HDR_STEP_LSB + NODE_ID_W;     // 34
   localparam int HDR_DST_LSB  = HDR_SRC_LSB + NODE_ID_W;      // 44
   localparam int HDR_FLG_LSB  = HDR_DST_LSB + NODE_ID_W;      // 54
   localparam int HDR_OPC_LSB  = HDR_FLG_LSB + FLG_W;          // 57
   localparam int HDR_TYPE_LSB = HDR_OPC_LSB + OPC_W;          // 62
   localparam int HDR_W        = HDR_TYPE_LSB + TYPE_W;        // 64

   // Node ID carried in the low bits of the header data
   localparam int HDR_NID_LSB = HDR_DAT_LSB;

   ////////////////////////////////////////
   // Encodings

   typedef enum logic [OPC_W-1:0] {
      OPC_GET_NET  = 5'b00001,
      OPC_SET_NET  = 5'b00010,
      OPC_SYNC1    = 5'b01000,
      OPC_UPDT_OFF = 5'b01101,
      OPC_SET_DT   = 5'b01110
   } qnet_opc_e;

   // Node parameter written in the tick cycle
   typedef enum logic [2:0] {
      P_NONE = 3'd0,
      P_ID   = 3'd1,
      P_NN   = 3'd2,
      P_OFF  = 3'd3,
      P_DT   = 3'd4
   } param_sel_e;

   typedef enum logic [1:0] {
      I_NOT_READY = 2'd0,
      I_IDLE      = 2'd1,
      I_BUSY      = 2'd2,
      I_WAIT_NREQ = 2'd3
   } intake_st_e;

   typedef enum logic [1:0] {
      X_IDLE      = 2'd0,
      X_WAIT_TICK = 2'd1,
      X_ERROR     = 2'd2,
      X_WAIT_TX   = 2'd3
   } exec_st_e;

   ////////////////////////////////////////
   // Timeout

   localparam int TIMEOUT_TICKS = 512;
   localparam int TO_CNT_W      = $clog2(TIMEOUT_TICKS + 1);

endpackage

//--- source/qnet_tx_hold.sv
`timescale 1ns/1ns

module qnet_tx_hold (
   input  logic                       t_clk_i,
   input  logic                       t_rst_ni,
   input  logic                       tx_load_i,
   input  logic                       flush_i,
   input  logic [qnet_pkg::HDR_W-1:0] tx_header_i,
   input  logic [qnet_pkg::DT_W-1:0]  tx_dt0_i,
   input  logic [qnet_pkg::DT_W-1:0]  tx_dt1_i,
   input  logic                       tx_ack_i,
   output logic                       tx_req_o,
   output logic [qnet_pkg::HDR_W-1:0] tx_header_o,
   output logic [qnet_pkg::DT_W-1:0]  tx_dt0_o,
   output logic [qnet_pkg::DT_W-1:0]  tx_dt1_o,
   output logic                       tx_done_o
);

   // Link takes the command in this cycle
   assign tx_done_o = tx_req_o & tx_ack_i;

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         tx_req_o <= 1'b0;
      end else begin
         if (flush_i)        tx_req_o <= 1'b0;
         else if (tx_load_i) tx_req_o <= 1'b1;
         else if (tx_done_o) tx_req_o <= 1'b0;
      end
   end

   // Held stable through back-pressure
   always_ff @(posedge t_clk_i) begin
      if (tx_load_i) begin
         tx_header_o <= tx_header_i;
         tx_dt0_o    <= tx_dt0_i;
         tx_dt1_o    <= tx_dt1_i;
      end
   end

endmodule

//--- tb.f
source/qnet_pkg.sv
source/qnet_cmd_intake.sv
source/qnet_cmd_exec.sv
source/qnet_tx_hold.sv
source/qnet_cmd_proc.sv
test/tb_clk_gen.sv
test/qnet_cmd_proc_sva.sv
test/tb_qnet_cmd_proc.sv

//--- test/qnet_cmd_proc_sva.sv
`timescale 1ns/1ns

module qnet_cmd_proc_sva (
   input logic                       t_clk_i,
   input logic                       t_rst_ni,
   input logic                       loc_cmd_ack_o,
   input logic                       net_cmd_ack_o,
   input logic                       tx_req_o,
   input logic                       tx_ack_i,
   input logic [qnet_pkg::HDR_W-1:0] tx_header_o,
   input qnet_pkg::param_sel_e       param_we_o,
   input logic                       cmd_error_o
);
   import qnet_pkg::*;

   // Only one source granted at a time
   a_one_ack: assert property (@(posedge t_clk_i) disable iff (!t_rst_ni)
      !(loc_cmd_ack_o && net_cmd_ack_o))
      else $error("both acknowledges high");

   a_hdr_stable: assert property (@(posedge t_clk_i) disable iff (!t_rst_ni)
      (tx_req_o && !tx_ack_i) |=> $stable(tx_header_o))
      else $error("tx header changed under back-pressure");

   // Parameter write is a single-cycle strobe
   a_we_pulse: assert property (@(posedge t_clk_i) disable iff (!t_rst_ni)
      (param_we_o != P_NONE) |=> (param_we_o == P_NONE))
      else $error("param write longer than one cycle");

   a_err_no_tx: assert property (@(posedge t_clk_i) disable iff (!t_rst_ni)
      !(cmd_error_o && $rose(tx_req_o)))
      else $error("error pulse with a new tx request");

endmodule

bind qnet_cmd_proc qnet_cmd_proc_sva u_sva (
   .t_clk_i       (t_clk_i),
   .t_rst_ni      (t_rst_ni),
   .loc_cmd_ack_o (loc_cmd_ack_o),
   .net_cmd_ack_o (net_cmd_ack_o),
   .tx_req_o      (tx_req_o),
   .tx_ack_i      (tx_ack_i),
   .tx_header_o   (tx_header_o),
   .param_we_o    (param_we_o),
   .cmd_error_o   (cmd_error_o)
);

//--- test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
   output logic clk_o,
   output logic rst_no
);

   localparam int HALF_PERIOD = 4;   // 8 ns clock
   localparam int RST_CYCLES  = 8;

   initial begin
      clk_o  = 1'b0;
      rst_no = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      #1 rst_no = 1'b1;
   end

   always #HALF_PERIOD clk_o = ~clk_o;

endmodule

//--- test/tb_qnet_cmd_proc.sv
`timescale 1ns/1ns

module tb_qnet_cmd_proc;
   import qnet_pkg::*;

   localparam int N_ROWS    = 10;
   localparam int MAX_CYCLE = N_ROWS * 40 + TIMEOUT_TICKS * 4 + 200;

   typedef struct packed {
      logic             net;
      logic             both;       // Both requests raised together
      logic [HDR_W-1:0] hdr;
      logic [DT_W-1:0]  dt0;
      logic [DT_W-1:0]  dt1;
      logic [DT_W-1:0]  tlink;
      logic [HDR_W-1:0] e_hdr;
      logic [DT_W-1:0]  e_dt0;
      logic [DT_W-1:0]  e_dt1;
      param_sel_e       e_psel;
      logic [DT_W-1:0]  e_pval;
      logic [2:0]       e_pulse;    // reset, init, updt
      logic             e_err;
   } row_t;

   logic clk;
   logic rst_n;
   logic link_ready;
   logic tick;
   logic [1:0] tick_div;
   logic [NODE_ID_W-1:0] node_id;
   logic [DT_W-1:0] t_link;
   logic loc_req;
   logic net_req;
   logic [HDR_W-1:0] cmd_header;
   logic [DT_W-1:0] cmd_dt0;
   logic [DT_W-1:0] cmd_dt1;
   logic tx_ack;
   logic loc_cmd_ack;
   logic net_cmd_ack;
   logic c_ready;
   logic cmd_error;
   param_sel_e param_we;
   logic [DT_W-1:0] param_dt;
   logic time_reset;
   logic time_init;
   logic time_updt;
   logic tx_req;
   logic [HDR_W-1:0] tx_header;
   logic [DT_W-1:0] tx_dt0;
   logic [DT_W-1:0] tx_dt1;

   row_t       rows [N_ROWS];
   int         n_rows;
   int         err_cnt;
   int         cycles;
   logic       link_en;
   logic [7:0] lfsr;

   tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

   qnet_cmd_proc u_dut (
      .t_clk_i       (clk),
      .t_rst_ni      (rst_n),
      .link_ready_i  (link_ready),
      .t_ready_i     (tick),
      .node_id_i     (node_id),
      .t_link_i      (t_link),
      .loc_cmd_req_i (loc_req),
      .net_cmd_req_i (net_req),
      .cmd_header_i  (cmd_header),
      .cmd_dt0_i     (cmd_dt0),
      .cmd_dt1_i     (cmd_dt1),
      .loc_cmd_ack_o (loc_cmd_ack),
      .net_cmd_ack_o (net_cmd_ack),
      .c_ready_o     (c_ready),
      .cmd_error_o   (cmd_error),
      .param_we_o    (param_we),
      .param_dt_o    (param_dt),
      .time_reset_o  (time_reset),
      .time_init_o   (time_init),
      .time_updt_o   (time_updt),
      .tx_req_o      (tx_req),
      .tx_header_o   (tx_header),
      .tx_dt0_o      (tx_dt0),
      .tx_dt1_o      (tx_dt1),
      .tx_ack_i      (tx_ack)
   );

   ////////////////////////////////////////
   // Helpers

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   // Taps 8,6,5,4
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic rand_bits(input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++) begin
         v    = (v << 1) | int'(lfsr[7]);
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic logic [HDR_W-1:0] make_hdr(input logic [4:0] opc, input logic [23:0] dat);
      return {2'b01, opc, 3'b101, 10'h155, 10'h0AA, 10'h003, dat};
   endfunction

   task automatic add_row(input logic net, input logic both, input logic [63:0] hdr,
                          input logic [31:0] dt0, input logic [31:0] dt1,
                          input logic [31:0] tl, input logic [63:0] e_hdr,
                          input logic [31:0] e_dt0, input logic [31:0] e_dt1,
                          input param_sel_e e_psel, input logic [31:0] e_pval,
                          input logic [2:0] e_pulse, input logic e_err);
      rows[n_rows] = '{net, both, hdr, dt0, dt1, tl, e_hdr, e_dt0, e_dt1,
                       e_psel, e_pval, e_pulse, e_err};
      n_rows++;
   endtask

   task automatic fill_table();
      logic [63:0] h;
      logic [31:0] d0;
      logic [31:0] d1;
      logic [31:0] tl;
      d0 = 32'h1000_0300;
      d1 = 32'h0000_0047;
      tl = 32'h0000_0051;
      // Local side
      h = make_hdr(OPC_GET_NET, 24'h000207);
      add_row(1'b0, 1'b0, h, d0, d1, tl, h, 32'h0, 32'h0, P_ID, 32'd1, 3'b100, 1'b0);
      h = make_hdr(OPC_SET_NET, 24'h000010);
      add_row(1'b0, 1'b0, h, d0, d1, tl, h, tl, 32'h0, P_NONE, 32'h0, 3'b100, 1'b0);
      h = make_hdr(OPC_SYNC1, 24'h000000);
      add_row(1'b0, 1'b1, h, d0, d1, tl, h, tl, 32'h0, P_NONE, 32'h0, 3'b100, 1'b0);
      h = make_hdr(OPC_UPDT_OFF, 24'h0000AB);
      add_row(1'b0, 1'b0, h, d0, d1, tl, h, d0, d1, P_NONE, 32'h0, 3'b000, 1'b0);
      // Network side
      h = make_hdr(OPC_GET_NET, 24'h000205);
      add_row(1'b1, 1'b0, h, d0, d1, tl, h + 64'd1, 32'h0, 32'h0, P_ID,
              {22'b0, h[9:0]}, 3'b000, 1'b0);
      h = make_hdr(OPC_SET_NET, 24'h00031C);
      add_row(1'b1, 1'b0, h, d0, d1, tl, h, d0, d1, P_NN, {22'b0, h[9:0]}, 3'b000, 1'b0);
      h = make_hdr(OPC_SYNC1, 24'h000001);
      add_row(1'b1, 1'b0, h, d0, d1, tl, h, d0 + tl, 32'h0, P_OFF, d0 + d1, 3'b010, 1'b0);
      h = make_hdr(OPC_UPDT_OFF, 24'h000002);
      add_row(1'b1, 1'b0, h, d1, d0, tl, h, d1, d0, P_OFF, d1, 3'b001, 1'b0);
      h = make_hdr(OPC_SET_DT, 24'h000003);
      add_row(1'b1, 1'b0, h, 32'd40, d1, tl, h, 32'd40, d1, P_DT, 32'd40, 3'b000, 1'b0);
      h = make_hdr(5'h1F, 24'h000004);   // Unknown opcode
      add_row(1'b1, 1'b0, h, d0, d1, tl, h, d0, d1, P_NONE, 32'h0, 3'b000, 1'b1);
   endtask

   ////////////////////////////////////////
   // Tick, link and watchdog models

   always @(posedge clk) begin
      #1;
      if (!rst_n) begin
         tick_div = 2'd0;
         tick     = 1'b0;
      end else begin
         tick_div = tick_div + 2'd1;
         tick     = (tick_div == 2'd0);   // Every fourth cycle
      end
   end

   // Acknowledges after 0 to 7 cycles and checks the held command
   always begin
      int          dly;
      logic [63:0] hold_hdr;
      logic [31:0] hold_dt0;
      logic [31:0] hold_dt1;
      @(posedge clk);
      #1;
      if (link_en && tx_req) begin
         hold_hdr = tx_header;
         hold_dt0 = tx_dt0;
         hold_dt1 = tx_dt1;
         rand_bits(3, dly);
         repeat (dly) begin
            @(posedge clk);
            #1;
            check_val("tx_req_o", 64'(tx_req), 64'd1);
            check_val("tx_header_o", tx_header, hold_hdr);
            check_val("tx_dt0_o", 64'(tx_dt0), 64'(hold_dt0));
            check_val("tx_dt1_o", 64'(tx_dt1), 64'(hold_dt1));
         end
         tx_ack = 1'b1;
         @(posedge clk);
         #1 tx_ack = 1'b0;
         check_val("tx_req_o", 64'(tx_req), 64'd0);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLE) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLE);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   end

   ////////////////////////////////////////
   // Row execution

   task automatic run_row(input row_t r);
      logic released;
      logic tx_seen;
      logic ack_seen;
      int   wr_cnt;
      int   rst_cnt;
      int   init_cnt;
      int   updt_cnt;
      int   err_seen;
      released = 1'b0;
      tx_seen  = 1'b0;
      ack_seen = 1'b0;
      wr_cnt   = 0;
      rst_cnt  = 0;
      init_cnt = 0;
      updt_cnt = 0;
      err_seen = 0;
      while (!c_ready) @(negedge clk);
      @(posedge clk);
      #1;
      cmd_header = r.hdr;
      cmd_dt0    = r.dt0;
      cmd_dt1    = r.dt1;
      t_link     = r.tlink;
      loc_req    = ~r.net;
      net_req    = r.net | r.both;
      while (!(released && c_ready)) begin
         @(negedge clk);
         if (r.net ? net_cmd_ack : loc_cmd_ack) ack_seen = 1'b1;
         check_val(r.net ? "loc_cmd_ack_o" : "net_cmd_ack_o",
                   64'(r.net ? loc_cmd_ack : net_cmd_ack), 64'd0);
         if (tx_req && !tx_seen) begin
            tx_seen = 1'b1;
            check_val("tx_header_o", tx_header, r.e_hdr);
            check_val("tx_dt0_o", 64'(tx_dt0), 64'(r.e_dt0));
            check_val("tx_dt1_o", 64'(tx_dt1), 64'(r.e_dt1));
         end
         if (param_we != P_NONE) begin
            wr_cnt++;
            check_val("param_we_o", 64'(param_we), 64'(r.e_psel));
            check_val("param_dt_o", 64'(param_dt), 64'(r.e_pval));
         end
         if (time_reset) rst_cnt++;
         if (time_init) init_cnt++;
         if (time_updt) updt_cnt++;
         if (cmd_error) err_seen++;
         if (r.both && loc_cmd_ack && net_req) begin
            @(posedge clk);
            #1 net_req = 1'b0;                 // Losing source withdraws
         end else if (!released && (r.e_err ? (err_seen > 0) : (tx_seen && !tx_req))) begin
            @(posedge clk);
            #1;
            loc_req  = 1'b0;
            net_req  = 1'b0;
            released = 1'b1;
            // Acknowledge must still be up when its request falls
            check_val("cmd_ack", 64'(loc_cmd_ack | net_cmd_ack), 64'd1);
         end
      end
      check_val("ack_seen", 64'(ack_seen), 64'd1);
      check_val("tx_req_seen", 64'(tx_seen), 64'(!r.e_err));
      check_val("param_write_cycles", 64'(wr_cnt), 64'(r.e_psel != P_NONE));
      check_val("time_reset_o_cycles", 64'(rst_cnt), 64'(r.e_pulse[2]));
      check_val("time_init_o_cycles", 64'(init_cnt), 64'(r.e_pulse[1]));
      check_val("time_updt_o_cycles", 64'(updt_cnt), 64'(r.e_pulse[0]));
      check_val("cmd_error_o_cycles", 64'(err_seen), 64'(r.e_err));
   endtask

   task automatic run_timeout();
      int ticks;
      ticks   = 0;
      link_en = 1'b0;                        // Link never answers
      while (!c_ready) @(negedge clk);
      @(posedge clk);
      #1;
      cmd_header = make_hdr(OPC_SET_DT, 24'h000009);
      cmd_dt0    = 32'd77;
      net_req    = 1'b1;
      while (!net_cmd_ack) @(negedge clk);
      while (net_cmd_ack) begin
         if (tick) ticks++;
         @(negedge clk);
      end
      check_val("ticks_to_abort", 64'(ticks), 64'(TIMEOUT_TICKS));
      @(posedge clk);
      #1 net_req = 1'b0;
      @(negedge clk);
      check_val("tx_req_o", 64'(tx_req), 64'd0);
      while (!c_ready) @(negedge clk);
      check_val("net_cmd_ack_o", 64'(net_cmd_ack), 64'd0);
      link_en = 1'b1;
   endtask

   ////////////////////////////////////////
   // Main sequence

   initial begin
      link_ready = 1'b1;
      tick       = 1'b0;
      tick_div   = 2'd0;
      node_id    = 10'h2A1;
      t_link     = '0;
      loc_req    = 1'b0;
      net_req    = 1'b0;
      cmd_header = '0;
      cmd_dt0    = '0;
      cmd_dt1    = '0;
      tx_ack     = 1'b0;
      link_en    = 1'b1;
      lfsr       = 8'd19;
      err_cnt    = 0;
      cycles     = 0;
      n_rows     = 0;
      fill_table();

      @(posedge rst_n);
      repeat (2) @(negedge clk);
      check_val("c_ready_o", 64'(c_ready), 64'd1);
      check_val("loc_cmd_ack_o", 64'(loc_cmd_ack), 64'd0);
      check_val("net_cmd_ack_o", 64'(net_cmd_ack), 64'd0);
      check_val("tx_req_o", 64'(tx_req), 64'd0);
      check_val("cmd_error_o", 64'(cmd_error), 64'd0);
      check_val("time_pulses", 64'({time_reset, time_init, time_updt}), 64'd0);
      check_val("param_we_o", 64'(param_we), 64'(P_NONE));

      for (int i = 0; i < n_rows; i++) run_row(rows[i]);
      run_timeout();

      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
